//--- verilog/gb_consts.svh
// #########################################################
// Address map and width constants for the Game Boy system bus.
// Include this file wherever a bus width, a region bound or
// a register address is needed.
// #########################################################
`ifndef GB_CONSTS_SVH
`define GB_CONSTS_SVH

// bus widths
`define GB_ADDR_W 16
`define GB_DATA_W 8

// work ram is 8 KiB
`define GB_WRAM_AW 13

// region bounds
`define GB_ROM_END 16'h7FFF
`define GB_BOOT_LIMIT 16'h0100
`define GB_WRAM_START 16'hC000
`define GB_WRAM_END 16'hDFFF
`define GB_ECHO_START 16'hE000
`define GB_ECHO_END 16'hFDFF

// memory mapped registers
`define GB_MMIO_CTRL 16'hFF00
`define GB_MMIO_IF 16'hFF0F
`define GB_MMIO_BOOT 16'hFF50
`define GB_MMIO_IE 16'hFFFF

// fixed read values
`define GB_CTRL_IDLE 8'hFF
`define GB_OPEN_BUS 8'h00

`endif

//--- verilog/gb_pkg.sv
// #########################################################
// Shared types of the Game Boy memory map: the decoded region
// and the interrupt byte layout used by IF and IE.
// Import into modules that carry a region or an IRQ byte.
// #########################################################
package gb_pkg;

   // decoded target of one bus access
   typedef enum logic [2:0] {
      REG_ROM,
      // echo area folds into this one
      REG_WRAM,
      REG_CTRL,
      REG_IF,
      REG_BOOT,
      REG_IE,
      REG_NONE
   } region_t;

   // bit layout shared by IF and IE, top bit first
   typedef struct packed {
      logic [2:0] unused;
      logic       hilo;
      logic       serial;
      logic       timer;
      logic       lcdc;
      logic       vblank;
   } irq_flags_t;

   // the same data byte, seen raw or as flags
   typedef union packed {
      logic [7:0] raw;
      irq_flags_t flags;
   } irq_byte_u;

endpackage

//--- verilog/gb_bus_if.sv
// #########################################################
// CPU-side bus inside the memory map. The top level drives it
// from its ports; the decoder and the targets attach by modport.
// #########################################################
`timescale 1ns/1ps
`include "gb_consts.svh"

interface gb_bus_if;

   logic [`GB_ADDR_W-1:0] addr;
   logic [`GB_DATA_W-1:0] wdata;
   // one-cycle strobes, never both high
   logic                  rd;
   logic                  wr;

   modport decoder (input addr, input wdata, input rd, input wr);

   // targets see only data and strobes, the region comes from the decoder
   modport target (input wdata, input rd, input wr);

endinterface

//--- verilog/bus_decode.sv
// #########################################################
// Address decoder of the memory map. Classifies every access
// into a region, forms the work RAM offset and flags accesses
// that fall inside the boot overlay.
// #########################################################
`timescale 1ns/1ps
`include "gb_consts.svh"

module bus_decode import gb_pkg::*; (
   gb_bus_if.decoder               bus,
   input  logic                    boot_done,
   output region_t                 region,
   output logic [`GB_WRAM_AW-1:0]  wram_addr,
   output logic                    rom_boot
);

   logic in_wram;
   logic in_echo;

   assign in_wram = (bus.addr >= `GB_WRAM_START) && (bus.addr <= `GB_WRAM_END);
   assign in_echo = (bus.addr >= `GB_ECHO_START) && (bus.addr <= `GB_ECHO_END);

   // rom first, then ram, then single registers
   always_comb begin
      region = REG_NONE;
      if (bus.addr <= `GB_ROM_END) begin
         region = REG_ROM;
      end else if (in_wram || in_echo) begin
         region = REG_WRAM;
      end else begin
         case (bus.addr)
            `GB_MMIO_CTRL: region = REG_CTRL;
            `GB_MMIO_IF:   region = REG_IF;
            `GB_MMIO_BOOT: region = REG_BOOT;
            `GB_MMIO_IE:   region = REG_IE;
            default:       region = REG_NONE;
         endcase
      end
   end

   // both windows start on an 8 KiB boundary, so the low address bits are the offset
   assign wram_addr = bus.addr[`GB_WRAM_AW-1:0];

   // boot image overlays the lowest rom page until boot ends
   assign rom_boot = !boot_done && (bus.addr < `GB_BOOT_LIMIT);

   // a strobe from the CPU side must always land in a known region
   always_comb begin
      if (bus.rd || bus.wr) begin
         region_known: assert final (!$isunknown(region))
            else $error("bus_decode: unknown region on a bus strobe");
      end
   end

endmodule

//--- verilog/work_ram.sv
// #########################################################
// 8 KiB work RAM behind C000-DFFF and its echo window.
// Single port block RAM with one cycle of read latency.
// #########################################################
`timescale 1ns/1ps
`include "gb_consts.svh"

module work_ram import gb_pkg::*; (
   input  logic                    clock,
   gb_bus_if.target                bus,
   input  region_t                 region,
   input  logic [`GB_WRAM_AW-1:0]  wram_addr,
   output logic [`GB_DATA_W-1:0]   ram_rdata
);

   localparam int DEPTH = 1 << `GB_WRAM_AW;

   logic [`GB_DATA_W-1:0] mem [DEPTH];
   logic                  wr_en;

   // the decoder already folded echo into REG_WRAM
   assign wr_en = bus.wr && (region == REG_WRAM);

   always_ff @(posedge clock) begin
      if (wr_en) begin
         mem[wram_addr] <= bus.wdata;
      end
   end

   // read port, data is ready the cycle after the strobe
   always_ff @(posedge clock) begin
      if (bus.rd) begin
         ram_rdata <= mem[wram_addr];
      end
   end

endmodule

//--- verilog/io_regs.sv
// #########################################################
// Boot, IF and IE registers of the memory map. Interrupt pulses
// set IF bits on top of any CPU write; IF and IE together give
// the pending-interrupt level.
// #########################################################
`timescale 1ns/1ps

module io_regs import gb_pkg::*; (
   input  logic       clock,
   input  logic       reset,
   gb_bus_if.target   bus,
   input  region_t    region,
   input  logic       irq_timer,
   input  logic       irq_vblank,
   input  logic       irq_lcdc,
   output logic       boot_done,
   output irq_byte_u  if_q,
   output irq_byte_u  ie_q,
   output logic       irq_pending
);

   irq_byte_u wr_byte;
   irq_byte_u if_next;
   irq_byte_u ie_next;
   logic      boot_q;

   assign wr_byte.raw = bus.wdata;

   // IF: CPU write first, then the requests
   always_comb begin
      if_next = if_q;
      if (bus.wr && (region == REG_IF)) begin
         if_next.raw          = '0;
         if_next.flags.timer  = wr_byte.flags.timer;
         if_next.flags.lcdc   = wr_byte.flags.lcdc;
         if_next.flags.vblank = wr_byte.flags.vblank;
      end
      if_next.flags.timer  = if_next.flags.timer | irq_timer;
      if_next.flags.lcdc   = if_next.flags.lcdc | irq_lcdc;
      if_next.flags.vblank = if_next.flags.vblank | irq_vblank;
   end

   // IE keeps all five flags
   always_comb begin
      ie_next = ie_q;
      if (bus.wr && (region == REG_IE)) begin
         ie_next.raw          = '0;
         ie_next.flags.hilo   = wr_byte.flags.hilo;
         ie_next.flags.serial = wr_byte.flags.serial;
         ie_next.flags.timer  = wr_byte.flags.timer;
         ie_next.flags.lcdc   = wr_byte.flags.lcdc;
         ie_next.flags.vblank = wr_byte.flags.vblank;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_q   <= '0;
         ie_q   <= '0;
         boot_q <= 1'b0;
      end else begin
         if_q <= if_next;
         ie_q <= ie_next;
         // once the overlay is off it stays off
         if (bus.wr && (region == REG_BOOT) && bus.wdata[0]) begin
            boot_q <= 1'b1;
         end
      end
   end

   assign boot_done   = boot_q;
   assign irq_pending = |(if_q.raw[4:0] & ie_q.raw[4:0]);

   unused_bits_zero: assert property (@(posedge clock) disable iff (reset)
      (if_q.flags.unused == 3'b000) && (ie_q.flags.unused == 3'b000) &&
      !if_q.flags.hilo && !if_q.flags.serial)
      else $error("io_regs: unused interrupt bits became set");

endmodule

//--- verilog/read_mux.sv
// #########################################################
// Read side of the memory map. Captures the region and the ROM
// byte at the read edge and registers the selected byte one
// cycle later, together with a one-cycle valid pulse.
// #########################################################
`timescale 1ns/1ps
`include "gb_consts.svh"

module read_mux import gb_pkg::*; (
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  rd,
   input  region_t               region,
   input  logic [`GB_DATA_W-1:0] rom_rdata,
   input  logic [`GB_DATA_W-1:0] ram_rdata,
   input  irq_byte_u             if_q,
   input  irq_byte_u             ie_q,
   output logic [`GB_DATA_W-1:0] rdata,
   output logic                  rdata_valid
);

   region_t               region_q;
   logic                  rd_q;
   logic [`GB_DATA_W-1:0] rom_q;
   logic [`GB_DATA_W-1:0] sel_data;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         region_q <= REG_NONE;
         rd_q     <= 1'b0;
      end else begin
         region_q <= region;
         rd_q     <= rd;
      end
   end

   // rom byte as presented at the read edge
   always_ff @(posedge clock) begin
      if (rd) begin
         rom_q <= rom_rdata;
      end
   end

   always_comb begin
      case (region_q)
         REG_ROM:  sel_data = rom_q;
         REG_WRAM: sel_data = ram_rdata;
         REG_IF:   sel_data = if_q.raw;
         REG_IE:   sel_data = ie_q.raw;
         REG_CTRL: sel_data = `GB_CTRL_IDLE;
         // boot register is write only, unmapped reads are open bus
         default:  sel_data = `GB_OPEN_BUS;
      endcase
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         rdata       <= '0;
         rdata_valid <= 1'b0;
      end else begin
         rdata_valid <= rd_q;
         if (rd_q) begin
            rdata <= sel_data;
         end
      end
   end

   // back-to-back valid only for back-to-back reads
   valid_follows_rd: assert property (@(posedge clock) disable iff (reset)
      (rdata_valid && $past(rdata_valid)) |-> ($past(rd, 2) && $past(rd, 3)))
      else $error("read_mux: rdata_valid held without back-to-back reads");

endmodule

//--- verilog/gb_memory_map.sv
// #########################################################
// Top level of the Game Boy system bus memory map. Plain CPU
// bus ports go onto the internal bus; decoder, work RAM, IO
// registers and read mux hang off it.
// #########################################################
`timescale 1ns/1ps
`include "gb_consts.svh"

module gb_memory_map import gb_pkg::*; (
   input  logic                  clock,
   input  logic                  reset,
   input  logic [`GB_ADDR_W-1:0] addr,
   input  logic [`GB_DATA_W-1:0] wdata,
   input  logic                  rd,
   input  logic                  wr,
   input  logic [`GB_DATA_W-1:0] rom_rdata,
   input  logic                  irq_timer,
   input  logic                  irq_vblank,
   input  logic                  irq_lcdc,
   output logic [`GB_DATA_W-1:0] rdata,
   output logic                  rdata_valid,
   output logic                  rom_boot,
   output logic                  irq_pending
);

   gb_bus_if bus_i ();

   region_t                region;
   logic [`GB_WRAM_AW-1:0] wram_addr;
   logic                   boot_done;
   logic [`GB_DATA_W-1:0]  ram_rdata;
   irq_byte_u              if_q;
   irq_byte_u              ie_q;

   assign bus_i.addr  = addr;
   assign bus_i.wdata = wdata;
   assign bus_i.rd    = rd;
   assign bus_i.wr    = wr;

   bus_decode decode_i (
      .bus       (bus_i),
      .boot_done (boot_done),
      .region    (region),
      .wram_addr (wram_addr),
      .rom_boot  (rom_boot)
   );

   work_ram wram_i (
      .clock     (clock),
      .bus       (bus_i),
      .region    (region),
      .wram_addr (wram_addr),
      .ram_rdata (ram_rdata)
   );

   io_regs regs_i (
      .clock       (clock),
      .reset       (reset),
      .bus         (bus_i),
      .region      (region),
      .irq_timer   (irq_timer),
      .irq_vblank  (irq_vblank),
      .irq_lcdc    (irq_lcdc),
      .boot_done   (boot_done),
      .if_q        (if_q),
      .ie_q        (ie_q),
      .irq_pending (irq_pending)
   );

   read_mux mux_i (
      .clock       (clock),
      .reset       (reset),
      .rd          (rd),
      .region      (region),
      .rom_rdata   (rom_rdata),
      .ram_rdata   (ram_rdata),
      .if_q        (if_q),
      .ie_q        (ie_q),
      .rdata       (rdata),
      .rdata_valid (rdata_valid)
   );

endmodule

//--- tb/tb_checks.svh
// ##########################################################
// Compare tasks, error counters, test constants and the random
// generator of the memory map testbench. Included inside the
// testbench module body.
// ##########################################################
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// cycles a read may take before it counts as lost
localparam int READ_TIMEOUT = 20;

// random work ram traffic
localparam int          RAND_WRITES = 64;
localparam logic [31:0] RAND_SEED   = 32'd3;

// echo window E000-FDFF covers only the first 1E00 bytes of work ram
localparam logic [12:0] ECHO_SPAN = 13'h1E00;

// IF keeps timer, lcdc and vblank; IE keeps all five flags
localparam logic [7:0] IF_MASK    = 8'h07;
localparam logic [7:0] IE_MASK    = 8'h1F;
localparam logic [7:0] IRQ_VBLANK = 8'h01;
localparam logic [7:0] IRQ_LCDC   = 8'h02;
localparam logic [7:0] IRQ_TIMER  = 8'h04;

int error_count = 0;
int check_count = 0;

task automatic check_byte(input string name, input logic [`GB_DATA_W-1:0] got,
                          input logic [`GB_DATA_W-1:0] exp);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("ERR %s: got %h, expected %h", name, got, exp);
   end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("ERR %s: got %h, expected %h", name, got, exp);
   end
endtask

// numerical recipes constants, full 32-bit period
function automatic logic [31:0] lcg_next(input logic [31:0] state);
   return state * 32'd1664525 + 32'd1013904223;
endfunction

`endif

//--- tb/tb_gb_memory_map.sv
// ##########################################################
// Directed testbench for the Game Boy memory map. Drives the
// CPU-side bus on the falling edge and checks read data, the
// boot overlay flag and the pending-interrupt level.
// ##########################################################
`timescale 1ns/1ps
`include "gb_consts.svh"

module tb_gb_memory_map;

   logic                  clock;
   logic                  reset;
   logic [`GB_ADDR_W-1:0] addr;
   logic [`GB_DATA_W-1:0] wdata;
   logic                  rd;
   logic                  wr;
   logic [`GB_DATA_W-1:0] rom_rdata;
   logic                  irq_timer;
   logic                  irq_vblank;
   logic                  irq_lcdc;
   logic [`GB_DATA_W-1:0] rdata;
   logic                  rdata_valid;
   logic                  rom_boot;
   logic                  irq_pending;

   // expected work ram contents for the random test
   logic [`GB_DATA_W-1:0] model [1 << `GB_WRAM_AW];

   `include "tb_checks.svh"

   gb_memory_map dut_i (
      .clock       (clock),
      .reset       (reset),
      .addr        (addr),
      .wdata       (wdata),
      .rd          (rd),
      .wr          (wr),
      .rom_rdata   (rom_rdata),
      .irq_timer   (irq_timer),
      .irq_vblank  (irq_vblank),
      .irq_lcdc    (irq_lcdc),
      .rdata       (rdata),
      .rdata_valid (rdata_valid),
      .rom_boot    (rom_boot),
      .irq_pending (irq_pending)
   );

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   task automatic do_write(input logic [15:0] a, input logic [7:0] d);
      @(negedge clock);
      addr  = a;
      wdata = d;
      wr    = 1'b1;
      @(negedge clock);
      wr = 1'b0;
   endtask

   // rom_rdata is inverted after the read edge, so only the sampled byte comes back
   task automatic do_read(input logic [15:0] a, output logic [7:0] d, output int lat);
      @(negedge clock);
      addr = a;
      rd   = 1'b1;
      @(negedge clock);
      rd        = 1'b0;
      rom_rdata = ~rom_rdata;
      lat       = 0;
      while (!rdata_valid && lat < READ_TIMEOUT) begin
         @(negedge clock);
         lat++;
      end
      if (!rdata_valid) begin
         error_count++;
         $display("timeout: rdata_valid never rose after a read of address %h", a);
      end
      d = rdata;
   endtask

   task automatic read_expect(input logic [15:0] a, input logic [7:0] exp, input string name);
      logic [7:0] d;
      int         lat;
      do_read(a, d, lat);
      check_byte(name, d, exp);
   endtask

   task automatic pulse_irq(input logic t, input logic v, input logic l);
      @(negedge clock);
      irq_timer  = t;
      irq_vblank = v;
      irq_lcdc   = l;
      @(negedge clock);
      irq_timer  = 1'b0;
      irq_vblank = 1'b0;
      irq_lcdc   = 1'b0;
   endtask

   // address held idle for a cycle, then the overlay flag is sampled
   task automatic rom_boot_at(input logic [15:0] a, input logic exp);
      @(negedge clock);
      addr = a;
      @(negedge clock);
      check_bit("rom_boot", rom_boot, exp);
   endtask

   task automatic report_test(input string name, input int errs_before);
      $display("test %-14s done, %0d new errors", name, error_count - errs_before);
   endtask

   task automatic test_wram_echo();
      int e0;
      e0 = error_count;
      do_write(16'hC000, 8'h11);
      do_write(16'hC123, 8'h5E);
      do_write(16'hDDFF, 8'hC7);
      read_expect(16'hC000, 8'h11, "rdata wram C000");
      read_expect(16'hE000, 8'h11, "rdata echo E000");
      read_expect(16'hC123, 8'h5E, "rdata wram C123");
      read_expect(16'hE123, 8'h5E, "rdata echo E123");
      read_expect(16'hDDFF, 8'hC7, "rdata wram DDFF");
      read_expect(16'hFDFF, 8'hC7, "rdata echo FDFF");
      // write through the mirror
      do_write(16'hE042, 8'hA5);
      read_expect(16'hC042, 8'hA5, "rdata wram after echo write");
      report_test("wram_echo", e0);
   endtask

   task automatic test_boot_overlay();
      int e0;
      e0 = error_count;
      rom_boot_at(16'h0000, 1'b1);
      rom_boot_at(16'h00FF, 1'b1);
      rom_boot_at(16'h0100, 1'b0);
      rom_rdata = 8'h3C;
      read_expect(16'h0010, 8'h3C, "rdata boot rom");
      rom_rdata = 8'h96;
      read_expect(16'h0150, 8'h96, "rdata cartridge rom");
      do_write(`GB_MMIO_BOOT, 8'h01);
      rom_boot_at(16'h0000, 1'b0);
      rom_boot_at(16'h00FF, 1'b0);
      rom_boot_at(16'h0100, 1'b0);
      rom_boot_at(16'h7FFF, 1'b0);
      report_test("boot_overlay", e0);
   endtask

   task automatic test_irq_flags();
      int e0;
      e0 = error_count;
      do_write(`GB_MMIO_IF, 8'h00);
      read_expect(`GB_MMIO_IF, 8'h00, "IF cleared");
      pulse_irq(1'b1, 1'b0, 1'b0);
      read_expect(`GB_MMIO_IF, IRQ_TIMER, "IF timer");
      pulse_irq(1'b0, 1'b1, 1'b0);
      read_expect(`GB_MMIO_IF, IRQ_TIMER | IRQ_VBLANK, "IF vblank");
      pulse_irq(1'b0, 1'b0, 1'b1);
      read_expect(`GB_MMIO_IF, IRQ_TIMER | IRQ_VBLANK | IRQ_LCDC, "IF lcdc");
      do_write(`GB_MMIO_IF, 8'h00);
      read_expect(`GB_MMIO_IF, 8'h00, "IF write zero");
      do_write(`GB_MMIO_IF, 8'hFF);
      read_expect(`GB_MMIO_IF, 8'hFF & IF_MASK, "IF write FF");
      // timer request lands on the same edge as the write
      @(negedge clock);
      addr      = `GB_MMIO_IF;
      wdata     = IRQ_VBLANK;
      wr        = 1'b1;
      irq_timer = 1'b1;
      @(negedge clock);
      wr        = 1'b0;
      irq_timer = 1'b0;
      read_expect(`GB_MMIO_IF, (IRQ_VBLANK | IRQ_TIMER) & IF_MASK, "IF write with request");
      do_write(`GB_MMIO_IE, 8'hFF);
      read_expect(`GB_MMIO_IE, 8'hFF & IE_MASK, "IE write FF");
      do_write(`GB_MMIO_IE, 8'h00);
      read_expect(`GB_MMIO_IE, 8'h00, "IE write zero");
      report_test("irq_flags", e0);
   endtask

   task automatic test_irq_pending();
      int e0;
      e0 = error_count;
      do_write(`GB_MMIO_IF, 8'h00);
      do_write(`GB_MMIO_IE, 8'h00);
      pulse_irq(1'b0, 1'b1, 1'b0);
      check_bit("irq_pending with IE zero", irq_pending, 1'b0);
      do_write(`GB_MMIO_IE, IRQ_TIMER);
      check_bit("irq_pending without shared bit", irq_pending, 1'b0);
      do_write(`GB_MMIO_IE, IRQ_TIMER | IRQ_VBLANK);
      check_bit("irq_pending with shared bit", irq_pending, 1'b1);
      do_write(`GB_MMIO_IF, 8'h00);
      check_bit("irq_pending after IF clear", irq_pending, 1'b0);
      do_write(`GB_MMIO_IE, 8'h00);
      report_test("irq_pending", e0);
   endtask

   // one valid pulse, one cycle after the read edge
   task automatic fixed_read(input logic [15:0] a, input logic [7:0] exp, input string name);
      logic [7:0] d;
      int         lat;
      do_read(a, d, lat);
      check_byte(name, d, exp);
      check_bit("rdata_valid one cycle after read", lat == 1, 1'b1);
      @(negedge clock);
      check_bit("rdata_valid pulse ends", rdata_valid, 1'b0);
   endtask

   task automatic test_fixed_reads();
      int e0;
      e0 = error_count;
      fixed_read(16'hFF00, 8'hFF, "rdata controller");
      fixed_read(16'hA000, 8'h00, "rdata unmapped A000");
      fixed_read(16'hFF40, 8'h00, "rdata unmapped FF40");
      fixed_read(16'hFE00, 8'h00, "rdata unmapped FE00");
      fixed_read(`GB_MMIO_BOOT, 8'h00, "rdata boot register");
      report_test("fixed_reads", e0);
   endtask

   task automatic test_random_ram();
      logic [31:0] rng;
      logic [12:0] off;
      logic [7:0]  val;
      logic [12:0] offs[$];
      int          i;
      int          e0;
      e0  = error_count;
      rng = RAND_SEED;
      for (i = 0; i < RAND_WRITES; i++) begin
         rng = lcg_next(rng);
         off = rng[28:16];
         // fold into the part that both windows reach
         if (off >= ECHO_SPAN) begin
            off = off - ECHO_SPAN;
         end
         val        = rng[7:0];
         model[off] = val;
         offs.push_back(off);
         if (i % 2 == 0) begin
            do_write(`GB_WRAM_START + {3'b000, off}, val);
         end else begin
            do_write(`GB_ECHO_START + {3'b000, off}, val);
         end
      end
      foreach (offs[k]) begin
         read_expect(`GB_WRAM_START + {3'b000, offs[k]}, model[offs[k]], "rdata random wram");
         read_expect(`GB_ECHO_START + {3'b000, offs[k]}, model[offs[k]], "rdata random echo");
      end
      report_test("random_ram", e0);
   endtask

   initial begin
      reset      = 1'b1;
      addr       = '0;
      wdata      = '0;
      rd         = 1'b0;
      wr         = 1'b0;
      rom_rdata  = '0;
      irq_timer  = 1'b0;
      irq_vblank = 1'b0;
      irq_lcdc   = 1'b0;
      repeat (5) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      test_wram_echo();
      test_boot_overlay();
      test_irq_flags();
      test_irq_pending();
      test_fixed_reads();
      test_random_ram();
      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

//--- src.f
+incdir+verilog
+incdir+tb
verilog/gb_pkg.sv
verilog/gb_bus_if.sv
verilog/bus_decode.sv
verilog/work_ram.sv
verilog/io_regs.sv
verilog/read_mux.sv
verilog/gb_memory_map.sv
tb/tb_gb_memory_map.sv

//--- Makefile
# Verilator build and run of the memory map testbench

VERILATOR ?= verilator
TOP       ?= tb_gb_memory_map
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -j 0

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
